// ==== common/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Word address width
// Bit 0 of the word address is byte address bit 1
`define SOC_ADR_W 19

// Data path width
`define SOC_DAT_W 16

// One select per byte lane
`define SOC_SEL_W 2

// GPIO window at I/O addresses 0xf100 to 0xf103
// Matched against {tga, adr[19:1]}
// The mask keeps the tag and I/O address bits 15 to 2
`define SOC_GPIO_ADR  20'h8_7880
`define SOC_GPIO_MASK 20'h8_7ffe

// Read data returned by the default target
`define SOC_DEF_DATA 16'hffff

// Board switch inputs
`define SOC_SW_W 10

// Board LED outputs
`define SOC_LED_W 14

// Timer tick period in clk cycles
`define SOC_TIMER_PERIOD 12507

`endif

// ==== common/wb_pkg.sv ====
`include "soc_params.svh"

package wb_pkg;

  // Request from the bus master
  // tga is set for I/O space accesses
  typedef struct packed {
    logic                  tga;
    logic [`SOC_ADR_W-1:0] adr;
    logic [`SOC_DAT_W-1:0] dat;
    logic [`SOC_SEL_W-1:0] sel;
    logic                  we;
    logic                  cyc;
    logic                  stb;
  } wb_req_t;

  // Response back to the master
  typedef struct packed {
    logic [`SOC_DAT_W-1:0] dat;
    logic                  ack;
  } wb_rsp_t;

  // Decoded target of an access
  typedef enum logic [1:0] {
    WB_TGT_GPIO = 2'd0,
    WB_TGT_DEF  = 2'd1
  } wb_target_e;

endpackage

// ==== common/irq_pkg.sv ====
package irq_pkg;

  // All request lines into the PIC
  // Line 0 is the timer
  typedef logic [7:0] irq_vec_t;

  // Board request lines 1 to 7
  typedef logic [7:1] irq_ext_t;

  // Index of the line being serviced
  typedef logic [2:0] irq_id_t;

endpackage

// ==== hw/wb_switch.sv ====
`timescale 1ns/1ps

`include "soc_params.svh"

module wb_switch
  import wb_pkg::*;
(
  input  wb_req_t m_req_i,
  output wb_rsp_t m_rsp_o,

  output wb_req_t gpio_req_o,
  input  wb_rsp_t gpio_rsp_i
);

  logic [`SOC_ADR_W:0] tag_adr;
  logic                gpio_hit;
  wb_target_e          tgt;

  logic    def_cyc;
  logic    def_stb;
  wb_rsp_t def_rsp;

  // Tag joins the address so memory and I/O spaces decode apart
  assign tag_adr = {m_req_i.tga, m_req_i.adr};

  assign gpio_hit = ((tag_adr ^ `SOC_GPIO_ADR) & `SOC_GPIO_MASK) == '0;

  always_comb begin
    if (gpio_hit) begin
      tgt = WB_TGT_GPIO;
    end else begin
      tgt = WB_TGT_DEF;
    end
  end

  // GPIO only sees cycle and strobe when it is addressed
  always_comb begin
    gpio_req_o = m_req_i;
    if (tgt != WB_TGT_GPIO) begin
      gpio_req_o.cyc = 1'b0;
      gpio_req_o.stb = 1'b0;
    end
  end

  // Default target
  // Answers everything unmapped at once and drops writes
  assign def_cyc = m_req_i.cyc & (tgt == WB_TGT_DEF);
  assign def_stb = m_req_i.stb & (tgt == WB_TGT_DEF);

  always_comb begin
    def_rsp.dat = `SOC_DEF_DATA;
    def_rsp.ack = def_cyc & def_stb;
  end

  // Response mux back to the master
  always_comb begin
    case (tgt)
      WB_TGT_GPIO: begin
        m_rsp_o = gpio_rsp_i;
      end
      WB_TGT_DEF: begin
        m_rsp_o = def_rsp;
      end
      default: begin
        m_rsp_o = def_rsp;
      end
    endcase
  end

endmodule

// ==== hw/gpio_regs.sv ====
`timescale 1ns/1ps

`include "soc_params.svh"

module gpio_regs
  import wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_lck,

  input  wb_req_t               req_i,
  output wb_rsp_t               rsp_o,

  input  logic [`SOC_SW_W-1:0]  sw_i,
  output logic [`SOC_LED_W-1:0] leds_o
);

  logic                  access;
  logic                  led_wr;
  logic [`SOC_LED_W-1:0] led_q;
  logic [`SOC_DAT_W-1:0] rd_dat;

  assign access = req_i.cyc & req_i.stb;

  // Word 1 (0xf102) holds the LEDs
  // Word 0 is read only
  assign led_wr = access & req_i.we & req_i.adr[0];

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      led_q <= '0;
    end else if (led_wr) begin
      if (req_i.sel[0]) begin
        led_q[7:0] <= req_i.dat[7:0];
      end
      // Upper lane only carries the bits that exist
      if (req_i.sel[1]) begin
        led_q[`SOC_LED_W-1:8] <= req_i.dat[`SOC_LED_W-1:8];
      end
    end
  end

  // Readback is zero extended to the bus width
  always_comb begin
    rd_dat = '0;
    if (req_i.adr[0]) begin
      rd_dat[`SOC_LED_W-1:0] = led_q;
    end else begin
      rd_dat[`SOC_SW_W-1:0] = sw_i;
    end
  end

  assign rsp_o.dat = rd_dat;
  assign rsp_o.ack = access;

  assign leds_o = led_q;

endmodule

// ==== irq/pit_timer.sv ====
`timescale 1ns/1ps

`include "soc_params.svh"

module pit_timer #(
  parameter int unsigned PERIOD = `SOC_TIMER_PERIOD
) (
  input  logic clk,
  input  logic rst_lck,
  output logic tick_o
);

  localparam int unsigned CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(PERIOD - 1);

  logic [CNT_W-1:0] cnt;
  logic             cnt_end;

  assign cnt_end = (cnt == '0);

  // Counts PERIOD cycles down to zero, then pulses and reloads
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt    <= RELOAD;
      tick_o <= 1'b0;
    end else if (cnt_end) begin
      cnt    <= RELOAD;
      tick_o <= 1'b1;
    end else begin
      cnt    <= cnt - 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// ==== irq/simple_pic.sv ====
`timescale 1ns/1ps

module simple_pic
  import irq_pkg::*;
(
  input  logic     clk,
  input  logic     rst_lck,

  input  irq_vec_t irq_i,
  input  logic     inta_i,

  output logic     intr_o,
  output irq_id_t  iid_o
);

  irq_vec_t irq_prev;
  irq_vec_t irq_edge;
  irq_vec_t pending;
  irq_vec_t ack_mask;
  logic     inta_prev;
  logic     inta_edge;
  irq_id_t  iid;

  // Edge triggered so a held line requests only once
  assign irq_edge  = irq_i & ~irq_prev;
  assign inta_edge = inta_i & ~inta_prev;

  // Lowest numbered line has priority
  always_comb begin
    iid = '0;
    for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid = irq_id_t'(i);
      end
    end
  end

  // Acknowledge retires the line currently on iid
  always_comb begin
    ack_mask = '0;
    if (inta_edge) begin
      ack_mask[iid] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_prev  <= '0;
      inta_prev <= 1'b0;
      pending   <= '0;
    end else begin
      irq_prev  <= irq_i;
      inta_prev <= inta_i;
      // A fresh edge wins over a clear in the same cycle
      pending   <= (pending & ~ack_mask) | irq_edge;
    end
  end

  assign intr_o = |pending;
  assign iid_o  = iid;

endmodule

// ==== hw/kotku_soc.sv ====
`timescale 1ns/1ps

`include "soc_params.svh"

module kotku_soc
  import wb_pkg::*;
  import irq_pkg::*;
#(
  parameter int unsigned TIMER_PERIOD = `SOC_TIMER_PERIOD
) (
  input  logic                  clk,
  input  logic                  rst_lck,

  // Bus master port
  input  wb_req_t               bus_req_i,
  output wb_rsp_t               bus_rsp_o,

  // Board I/O
  input  logic [`SOC_SW_W-1:0]  sw_i,
  output logic [`SOC_LED_W-1:0] leds_o,

  // Interrupt path
  input  irq_ext_t              irq_ext_i,
  input  logic                  inta_i,
  output logic                  intr_o,
  output irq_id_t               iid_o
);

  wb_req_t  gpio_req;
  wb_rsp_t  gpio_rsp;
  logic     timer_tick;
  irq_vec_t irq_vec;

  // Timer sits on line 0 ahead of the board lines
  assign irq_vec = {irq_ext_i, timer_tick};

  wb_switch u_wb_switch (
    .m_req_i    (bus_req_i),
    .m_rsp_o    (bus_rsp_o),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  // Switches and LEDs at 0xf100
  gpio_regs u_gpio_regs (
    .clk     (clk),
    .rst_lck (rst_lck),
    .req_i   (gpio_req),
    .rsp_o   (gpio_rsp),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

  pit_timer #(
    .PERIOD (TIMER_PERIOD)
  ) u_pit_timer (
    .clk     (clk),
    .rst_lck (rst_lck),
    .tick_o  (timer_tick)
  );

  simple_pic u_simple_pic (
    .clk     (clk),
    .rst_lck (rst_lck),
    .irq_i   (irq_vec),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid_o)
  );

endmodule

// ==== sim/tb_kotku_soc.sv ====
`timescale 1ns/1ps

`include "soc_params.svh"

module tb_kotku_soc
  import wb_pkg::*;
  import irq_pkg::*;
();

  localparam int unsigned TIMER_PERIOD    = 40;
  localparam int unsigned RST_CYCLES      = 16;
  localparam int unsigned NUM_TESTS       = 5;
  localparam int unsigned WATCHDOG_CYCLES = NUM_TESTS * 200 + 4 * TIMER_PERIOD;
  localparam logic [31:0] LFSR_SEED       = 32'he0a4_488b;

  // Word addresses of the GPIO block in I/O space
  localparam logic [`SOC_ADR_W-1:0] GPIO_W0 = `SOC_ADR_W'(20'hf100 >> 1);
  localparam logic [`SOC_ADR_W-1:0] GPIO_W1 = `SOC_ADR_W'(20'hf102 >> 1);

  logic                  clk;
  logic                  rst_lck;
  wb_req_t               bus_req;
  wb_rsp_t               bus_rsp;
  logic [`SOC_SW_W-1:0]  sw;
  logic [`SOC_LED_W-1:0] leds;
  irq_ext_t              irq_ext;
  logic                  inta;
  logic                  intr;
  irq_id_t               iid;

  logic [31:0]           lfsr_state;
  logic [`SOC_LED_W-1:0] led_model;
  string                 test_name;

  kotku_soc #(
    .TIMER_PERIOD (TIMER_PERIOD)
  ) u_kotku_soc (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .sw_i      (sw),
    .leds_o    (leds),
    .irq_ext_i (irq_ext),
    .inta_i    (inta),
    .intr_o    (intr),
    .iid_o     (iid)
  );

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_data(input string name, input logic [`SOC_DAT_W-1:0] exp,
                            input logic [`SOC_DAT_W-1:0] act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // One bus cycle with the response sampled in the low phase
  task automatic drive_cycle(input wb_req_t req, output wb_rsp_t rsp);
    @(negedge clk);
    bus_req = req;
    #1;
    rsp = bus_rsp;
    if (rsp.ack !== 1'b1) begin
      $display("No acknowledge in %s for word address %h", test_name, req.adr);
      abort_run();
    end
    @(negedge clk);
    bus_req = '0;
  endtask

  task automatic bus_write(input logic tga, input logic [`SOC_ADR_W-1:0] adr,
                           input logic [`SOC_DAT_W-1:0] dat, input logic [`SOC_SEL_W-1:0] sel);
    wb_req_t req;
    wb_rsp_t rsp;
    req = '{tga: tga, adr: adr, dat: dat, sel: sel, we: 1'b1, cyc: 1'b1, stb: 1'b1};
    drive_cycle(req, rsp);
  endtask

  task automatic bus_read(input logic tga, input logic [`SOC_ADR_W-1:0] adr,
                          output logic [`SOC_DAT_W-1:0] dat);
    wb_req_t req;
    wb_rsp_t rsp;
    req = '{tga: tga, adr: adr, dat: '0, sel: '1, we: 1'b0, cyc: 1'b1, stb: 1'b1};
    drive_cycle(req, rsp);
    dat = rsp.dat;
  endtask

  task automatic pulse_inta();
    @(negedge clk);
    inta = 1'b1;
    @(negedge clk);
    inta = 1'b0;
  endtask

  task automatic drain_pending();
    @(negedge clk);
    for (int i = 0; i < 16 && intr; i++) begin
      pulse_inta();
    end
    if (intr) begin
      $display("Pending interrupts in %s did not clear after acknowledges", test_name);
      abort_run();
    end
  endtask

  task automatic wait_intr(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (!intr && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!intr) begin
      $display("No interrupt request in %s within %0d cycles", test_name, max_cycles);
      abort_run();
    end
  endtask

  task automatic test_reset_and_switches();
    logic [31:0]           r;
    logic [`SOC_DAT_W-1:0] d;
    test_name = "reset_and_switches";
    check_data(test_name, '0, `SOC_DAT_W'(leds));
    check_bit(test_name, 1'b0, intr);
    bus_read(1'b1, GPIO_W1, d);
    check_data(test_name, '0, d);
    for (int i = 0; i < 6; i++) begin
      take_bits(`SOC_SW_W, r);
      @(negedge clk);
      sw = r[`SOC_SW_W-1:0];
      bus_read(1'b1, GPIO_W0, d);
      check_data(test_name, `SOC_DAT_W'(r[`SOC_SW_W-1:0]), d);
    end
  endtask

  task automatic test_led_register();
    logic [31:0]           r;
    logic [`SOC_DAT_W-1:0] d;
    test_name = "led_register";
    for (int i = 0; i < 6; i++) begin
      take_bits(`SOC_DAT_W, r);
      bus_write(1'b1, GPIO_W1, r[`SOC_DAT_W-1:0], 2'b11);
      led_model = r[`SOC_LED_W-1:0];
      check_data(test_name, `SOC_DAT_W'(led_model), `SOC_DAT_W'(leds));
      bus_read(1'b1, GPIO_W1, d);
      check_data(test_name, `SOC_DAT_W'(led_model), d);
    end
    // Low lane alone, then high lane alone
    take_bits(`SOC_DAT_W, r);
    bus_write(1'b1, GPIO_W1, r[`SOC_DAT_W-1:0], 2'b01);
    led_model[7:0] = r[7:0];
    check_data(test_name, `SOC_DAT_W'(led_model), `SOC_DAT_W'(leds));
    take_bits(`SOC_DAT_W, r);
    bus_write(1'b1, GPIO_W1, r[`SOC_DAT_W-1:0], 2'b10);
    led_model[`SOC_LED_W-1:8] = r[`SOC_LED_W-1:8];
    check_data(test_name, `SOC_DAT_W'(led_model), `SOC_DAT_W'(leds));
    bus_read(1'b1, GPIO_W1, d);
    check_data(test_name, `SOC_DAT_W'(led_model), d);
    // Switch word is read only
    take_bits(`SOC_DAT_W, r);
    bus_write(1'b1, GPIO_W0, r[`SOC_DAT_W-1:0], 2'b11);
    bus_read(1'b1, GPIO_W0, d);
    check_data(test_name, `SOC_DAT_W'(sw), d);
    check_data(test_name, `SOC_DAT_W'(led_model), `SOC_DAT_W'(leds));
  endtask

  task automatic check_default(input logic tga, input logic [19:0] byte_adr);
    logic [31:0]           r;
    logic [`SOC_DAT_W-1:0] d;
    bus_read(tga, byte_adr[19:1], d);
    check_data(test_name, `SOC_DAT_W'(`SOC_DEF_DATA), d);
    take_bits(`SOC_DAT_W, r);
    bus_write(tga, byte_adr[19:1], r[`SOC_DAT_W-1:0], 2'b11);
    check_data(test_name, `SOC_DAT_W'(led_model), `SOC_DAT_W'(leds));
  endtask

  task automatic test_default_target();
    logic [31:0] r;
    test_name = "default_target";
    check_default(1'b1, 20'h0_f104);
    check_default(1'b1, 20'h0_0060);
    check_default(1'b1, 20'h0_f0fe);
    // Memory space never reaches the GPIO block
    check_default(1'b0, 20'h0_f100);
    check_default(1'b0, 20'h0_f102);
    take_bits(20, r);
    check_default(1'b0, r[19:0]);
  endtask

  task automatic test_timer_irq();
    test_name = "timer_irq";
    drain_pending();
    wait_intr(2 * TIMER_PERIOD);
    check_id(test_name, 3'd0, iid);
    pulse_inta();
    check_bit(test_name, 1'b0, intr);
  endtask

  task automatic test_ext_priority();
    test_name = "ext_priority";
    // Start just after a tick so the timer stays quiet for most of a period
    drain_pending();
    wait_intr(2 * TIMER_PERIOD);
    pulse_inta();
    @(negedge clk);
    irq_ext[3] = 1'b1;
    irq_ext[5] = 1'b1;
    @(negedge clk);
    if (intr && iid == 3'd0) begin
      pulse_inta();
    end
    check_bit(test_name, 1'b1, intr);
    check_id(test_name, 3'd3, iid);
    pulse_inta();
    check_id(test_name, 3'd5, iid);
    pulse_inta();
    check_bit(test_name, 1'b0, intr);
    // Lines stay high without a new edge
    repeat (8) @(negedge clk);
    check_bit(test_name, 1'b0, intr);
    irq_ext = '0;
    @(negedge clk);
    irq_ext[5] = 1'b1;
    @(negedge clk);
    check_bit(test_name, 1'b1, intr);
    check_id(test_name, 3'd5, iid);
    pulse_inta();
    check_bit(test_name, 1'b0, intr);
    irq_ext = '0;
  endtask

  initial begin
    rst_lck    = 1'b0;
    bus_req    = '0;
    sw         = '0;
    irq_ext    = '0;
    inta       = 1'b0;
    lfsr_state = LFSR_SEED;
    led_model  = '0;
    test_name  = "reset";
    repeat (RST_CYCLES) @(negedge clk);
    rst_lck = 1'b1;
    @(negedge clk);
    test_reset_and_switches();
    test_led_register();
    test_default_target();
    test_timer_irq();
    test_ext_priority();
    $display("No errors");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles during %s", WATCHDOG_CYCLES, test_name);
    abort_run();
  end

endmodule

// ==== compile.f ====
+incdir+common
common/wb_pkg.sv
common/irq_pkg.sv
hw/wb_switch.sv
hw/gpio_regs.sv
irq/pit_timer.sv
irq/simple_pic.sv
hw/kotku_soc.sv
sim/tb_kotku_soc.sv
